// ==== list.f ====
verilog/xbuf_pkg.sv
verilog/xbuf_pad_scm.sv
verilog/xbuf_shift_scm.sv
verilog/xbuf_ctrl.sv
verilog/xbuf_top.sv
tests/xbuf_clk_gen.sv
tests/xbuf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the X staging path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module xbuf_tb -Mdir obj_dir -o xbuf_sim

./obj_dir/xbuf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// ==== tests/xbuf_clk_gen.sv ====
/*
  Free-running 20 ns clock and an active-low reset held for 3 cycles.
  Reset is released 2 ns after a rising edge.
*/
`timescale 1ns/1ps
`default_nettype none

module xbuf_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
  end

  always #10 clk_o = ~clk_o;

  initial begin
    repeat (3) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/xbuf_tb.sv ====
/*
  Trace-driven testbench of the X staging path.
  Each trace line is one clock cycle; inputs are applied 2 ns after the
  rising edge and marked lines are compared at the falling edge.
  Run from the project root so the trace path resolves.
*/
`timescale 1ns/1ps
`default_nettype none

module xbuf_tb
  import xbuf_pkg::*;
;

  localparam int unsigned XB_W = ELEM_W * ARRAY_W * ARRAY_H;

  typedef logic [XB_W-1:0] xb_vec_t;

  // One cycle of stimulus and its expected response
  typedef struct packed {
    xbuf_ctrl_t ctrl;
    logic       clear;
    data_word_t data;
    logic       chk;
    logic       full;
    logic       empty;
    xb_vec_t    xbuf;
  } trace_t;

  logic        clk;
  logic        rst_n;
  logic        clear;
  xbuf_ctrl_t  ctrl;
  data_word_t  data;
  xbuf_flags_t flags;
  xb_vec_t     x_buf;

  trace_t      trace_q[$];
  logic        trace_loaded;
  int unsigned errors;
  int unsigned checks;

  xbuf_clk_gen xbuf_clk_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  xbuf_top xbuf_top_inst (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .clear_i    (clear),
    .ctrl_i     (ctrl),
    .data_i     (data),
    .flags_o    (flags),
    .x_buffer_o (x_buf)
  );

  task automatic check_val(input string name, input xb_vec_t exp, input xb_vec_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Lines starting with # are comments, blank lines are skipped
  task automatic read_trace();
    int     fd;
    int     rc;
    int     line_no;
    string  line;
    logic [31:0] ps, ld, hs, rwi, clr, lx, wd, ht, sl, chk, fu, em;
    logic [DATA_W-1:0] dat;
    xb_vec_t xb;
    trace_t ent;
    fd = $fopen("tests/xbuf_trace.txt", "r");
    line_no = 0;
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file tests/xbuf_trace.txt");
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      line_no++;
      if (rc == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
        continue;
      end
      rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   ps, ld, hs, rwi, clr, lx, wd, ht, sl, dat, chk, fu, em, xb);
      if (rc != 14) begin
        errors++;
        $display("Trace line %0d could not be parsed", line_no);
        continue;
      end
      ent                  = '0;
      ent.ctrl.pad_setup   = ps[0];
      ent.ctrl.load        = ld[0];
      ent.ctrl.h_shift     = hs[0];
      ent.ctrl.rst_w_index = rwi[0];
      ent.ctrl.last_x      = lx[0];
      ent.ctrl.width       = row_cnt_t'(wd);
      ent.ctrl.height      = col_cnt_t'(ht);
      ent.ctrl.slots       = col_cnt_t'(sl);
      ent.clear            = clr[0];
      ent.data             = dat;
      ent.chk              = chk[0];
      ent.full             = fu[0];
      ent.empty            = em[0];
      ent.xbuf             = xb;
      trace_q.push_back(ent);
    end
    $fclose(fd);
  endtask

  task automatic compare_line(input int unsigned idx, input trace_t ent);
    check_val($sformatf("line %0d full", idx + 1), xb_vec_t'(ent.full), xb_vec_t'(flags.full));
    check_val($sformatf("line %0d empty", idx + 1), xb_vec_t'(ent.empty),
              xb_vec_t'(flags.empty));
    check_val($sformatf("line %0d x_buffer", idx + 1), ent.xbuf, x_buf);
  endtask

  initial begin : run_trace
    int unsigned idx;
    clear        = 1'b0;
    ctrl         = '0;
    data         = '0;
    errors       = 0;
    checks       = 0;
    trace_loaded = 1'b0;
    read_trace();
    trace_loaded = 1'b1;
    @(posedge rst_n);
    for (idx = 0; idx < trace_q.size(); idx++) begin
      @(posedge clk);
      #2;
      ctrl  = trace_q[idx].ctrl;
      clear = trace_q[idx].clear;
      data  = trace_q[idx].data;
      @(negedge clk);
      if (trace_q[idx].chk) begin
        compare_line(idx, trace_q[idx]);
      end
    end
    @(posedge clk);
    #2;
    ctrl  = '0;
    clear = 1'b0;
    if (trace_q.size() == 0) begin
      errors++;
      $display("The trace holds no cycles to run");
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Limit grows with the trace length
  initial begin : watchdog
    longint limit;
    wait (trace_loaded);
    limit = longint'(trace_q.size()) * 20 + 200;
    #(limit);
    $display("Timeout: the trace did not finish within %0d ns", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/xbuf_trace.txt ====
# pad_setup load h_shift rst_w_index clear last_x width height slots data_i(hex)
# check full empty x_buffer_o(hex, row 3 pe 3 first)
0 1 0 0 0 0 4 8 8 00070006000500040003000200010000 0 0 0 0
0 1 0 0 0 0 4 8 8 00170016001500140013001200110010 0 0 0 0
0 1 0 0 0 0 4 8 8 00270026002500240023002200210020 0 0 0 0
0 1 0 0 0 0 4 8 8 00370036003500340033003200310030 0 0 0 0
0 0 0 0 0 0 4 8 8 0 1 1 0 0
0 0 0 0 0 0 4 8 8 0 1 1 0 0
1 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 1 1 0 0033003200310030002300220021002000130012001100100003000200010000
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 1 1 0 0033003200310030002300220021002000130012001100100003000200010000
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 8 8 0 1 1 0 0037003600350034002700260025002400170016001500140007000600050004
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 0 0 0 0
0 0 1 0 0 0 4 8 8 0 1 1 0 0033003200310030002300220021002000130012001100100003000200010000
0 0 1 0 0 0 4 8 8 0 1 1 1 0033003200310030002300220021002000130012001100100003000200010000
0 0 0 0 0 0 4 8 8 0 1 1 0 0033003200310030002300220021002000130012001100100003000200010000
0 0 0 0 1 0 4 8 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 1 0 0 0
0 1 0 0 0 0 4 6 8 00070006000500040003000200010000 0 0 0 0
0 1 0 0 0 0 4 6 8 00170016001500140013001200110010 0 0 0 0
0 1 0 0 0 0 4 6 8 00270026002500240023002200210020 0 0 0 0
0 1 0 0 0 0 4 6 8 00370036003500340033003200310030 0 0 0 0
0 0 0 0 0 0 4 6 8 0 1 1 0 0
1 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 0 0 0 0
0 0 1 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 1 1 0 0033003200310030002300220021002000130012001100100003000200010000
0 0 1 0 0 0 4 6 8 0 0 0 0 0
0 0 1 0 0 0 4 6 8 0 0 0 0 0
0 0 1 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 1 1 0 0033003200310030002300220021002000130012001100100003000200010000
0 0 1 0 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 1 1 0 0000000000350034000000000025002400000000001500140000000000050004
0 0 0 1 0 0 4 6 8 0 0 0 0 0
0 0 0 0 0 0 4 6 8 0 1 0 0 0000000000350034000000000025002400000000001500140000000000050004

// ==== verilog/xbuf_ctrl.sv ====
/*
  Fill controller of the X staging path.
  full is combinational and holds until rst_w_index; empty is a one-cycle
  pulse on the h_shift that consumes the last programmed column.
  Columns whose read count exceeds height are flagged for zero padding.
*/
`timescale 1ns/1ps
`default_nettype none

module xbuf_ctrl
  import xbuf_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        clear_i,
  input  wire xbuf_ctrl_t  ctrl_i,
  output xbuf_flags_t      flags_o,
  output logic             pad_we_o,
  output row_cnt_t         pad_wrow_o,
  output logic             pad_re_o,
  output pad_addr_t        pad_raddr_o,
  output logic             buf_we_o,
  output slot_addr_t       buf_waddr_o,
  output logic             buf_wzero_o,
  output logic             buf_rbank_o
);

  xbuf_state_e state_q, state_d;

  row_cnt_t    w_index_q;
  pad_addr_t   pad_raddr_q, pad_raddr_d;
  col_cnt_t    pad_read_cnt_q;
  fill_cnt_t   fill_cnt_q;
  slot_addr_t  rd_slot_q, wr_slot_q;
  logic        first_block_q, refilling_q;

  logic        full, empty;
  logic        buf_we, pad_re;
  logic        read_all;
  logic        fast_fill_done;
  logic        last_rd_slot;

  assign full     = w_index_q == ctrl_i.width;
  assign empty    = (pad_read_cnt_q >= ctrl_i.slots) && ctrl_i.h_shift;
  assign read_all = pad_read_cnt_q == ctrl_i.slots;

  // The fill counter lags by one write, so compare against its next value
  assign fast_fill_done = fill_cnt_t'(pad_raddr_q) == fill_cnt_q - fill_cnt_t'(1);
  assign last_rd_slot   = rd_slot_q[SLOT_IDX_W-1:0] == SLOT_IDX_W'(ARRAY_H - 1);

  // Fast fill writes every cycle, normal fill only when a slot is freed
  assign buf_we = (state_q == FAST_FILL || (state_q == FILL && ctrl_i.h_shift)) && !refilling_q;
  assign pad_re = buf_we || ctrl_i.pad_setup;

  assign pad_raddr_d = (col_cnt_t'(pad_raddr_q) < ctrl_i.slots - col_cnt_t'(1)) ?
                       pad_raddr_q + pad_addr_t'(1) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PRELOAD;
    end else if (clear_i) begin
      state_q <= PRELOAD;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      PRELOAD: begin
        if (ctrl_i.pad_setup) begin
          state_d = FAST_FILL;
        end
      end
      FAST_FILL: begin
        if (fast_fill_done && (!ctrl_i.h_shift || first_block_q || read_all)) begin
          if (read_all && !full) begin
            state_d = PAD_EMPTY;
          end else if (first_block_q) begin
            state_d = WAIT_FIRST_READ;
          end else if (read_all) begin
            // Pad drained, only the empty pulse on the next shift is left
            state_d = WAIT_SHIFT;
          end else begin
            state_d = FILL;
          end
        end
      end
      WAIT_FIRST_READ: begin
        if (last_rd_slot && ctrl_i.h_shift) begin
          state_d = ctrl_i.rst_w_index ? PAD_EMPTY : FILL;
        end
      end
      WAIT_SHIFT: begin
        if (ctrl_i.h_shift) begin
          state_d = PAD_EMPTY;
        end
      end
      FILL: begin
        // A one-row block is full again at the same time as it empties
        if (empty && !full) begin
          state_d = PAD_EMPTY;
        end
      end
      PAD_EMPTY: begin
        if (full) begin
          state_d = (fill_cnt_q != '0 || ctrl_i.h_shift) ? FAST_FILL : FILL;
        end
      end
      default: state_d = PRELOAD;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_block_q <= 1'b0;
      refilling_q   <= 1'b1;
    end else if (clear_i) begin
      first_block_q <= 1'b0;
      refilling_q   <= 1'b1;
    end else begin
      if (pad_raddr_q == pad_addr_t'(BUF_SLOTS - 1)) begin
        first_block_q <= 1'b0;
      end else if (ctrl_i.pad_setup) begin
        first_block_q <= 1'b1;
      end
      if (full) begin
        refilling_q <= 1'b0;
      end else if (empty) begin
        refilling_q <= 1'b1;
      end
    end
  end

  // Row count is cleared by the scheduler once it has seen full
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_index_q <= '0;
    end else if (clear_i || ctrl_i.rst_w_index) begin
      w_index_q <= '0;
    end else if (ctrl_i.load) begin
      w_index_q <= w_index_q + row_cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pad_raddr_q    <= '0;
      pad_read_cnt_q <= '0;
      fill_cnt_q     <= '0;
    end else if (clear_i) begin
      pad_raddr_q    <= '0;
      pad_read_cnt_q <= '0;
      fill_cnt_q     <= '0;
    end else begin
      if (buf_we) begin
        pad_raddr_q <= pad_raddr_d;
      end
      if (empty) begin
        pad_read_cnt_q <= col_cnt_t'(1);
      end else if (pad_re) begin
        pad_read_cnt_q <= pad_read_cnt_q + col_cnt_t'(1);
      end
      if (empty) begin
        fill_cnt_q <= '0;
      end else if ((state_q == PAD_EMPTY || (state_q == FAST_FILL && !first_block_q)) &&
                   ctrl_i.h_shift) begin
        fill_cnt_q <= fill_cnt_q + fill_cnt_t'(1);
      end else if (ctrl_i.pad_setup) begin
        fill_cnt_q <= fill_cnt_t'(BUF_SLOTS);
      end
    end
  end

  // Slot pointers carry from the slot index into the bank bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_slot_q <= '0;
      wr_slot_q <= '0;
    end else if (clear_i) begin
      rd_slot_q <= '0;
      wr_slot_q <= '0;
    end else begin
      if (ctrl_i.h_shift) begin
        rd_slot_q <= rd_slot_q + slot_addr_t'(1);
      end
      if (buf_we) begin
        wr_slot_q <= wr_slot_q + slot_addr_t'(1);
      end
    end
  end

  assign flags_o.full  = full;
  assign flags_o.empty = empty;

  assign pad_we_o    = ctrl_i.load;
  assign pad_wrow_o  = w_index_q;
  assign pad_re_o    = pad_re;
  assign pad_raddr_o = ctrl_i.pad_setup ? '0 : pad_raddr_d;
  assign buf_we_o    = buf_we;
  assign buf_waddr_o = wr_slot_q;
  assign buf_wzero_o = pad_read_cnt_q > ctrl_i.height;
  assign buf_rbank_o = rd_slot_q[SLOT_IDX_W];

endmodule

`default_nettype wire

// ==== verilog/xbuf_pad_scm.sv ====
/*
  Pad register file of ARRAY_W rows by TOT_DEPTH elements.
  A write stores one whole streamer word as a row; writes to a row index
  at or above ARRAY_W are dropped. Read data appears one cycle after read_en_i.
*/
`timescale 1ns/1ps
`default_nettype none

module xbuf_pad_scm
  import xbuf_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       clear_i,
  input  wire logic       write_en_i,
  input  wire row_cnt_t   write_row_i,
  input  wire data_word_t wdata_i,
  input  wire logic       read_en_i,
  input  wire pad_addr_t  read_addr_i,
  output pad_col_t        rdata_o
);

  elem_t [TOT_DEPTH-1:0] rows_q [ARRAY_W];
  logic                  row_ok;

  assign row_ok = write_row_i < row_cnt_t'(ARRAY_W);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < ARRAY_W; r++) begin
        rows_q[r] <= '0;
      end
    end else if (clear_i) begin
      for (int r = 0; r < ARRAY_W; r++) begin
        rows_q[r] <= '0;
      end
    end else if (write_en_i && row_ok) begin
      rows_q[write_row_i[ROW_IDX_W-1:0]] <= wdata_i;
    end
  end

  // One element of every row forms the column sent to the buffer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (clear_i) begin
      rdata_o <= '0;
    end else if (read_en_i) begin
      for (int r = 0; r < ARRAY_W; r++) begin
        rdata_o[r] <= rows_q[r][read_addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/xbuf_pkg.sv ====
/*
  Shared constants and types of the X operand staging path.
  ARRAY_H must be a power of two, since the buffer slot pointer carries
  from the slot index straight into the bank bit.
*/
`default_nettype none

package xbuf_pkg;

  localparam int unsigned ELEM_W     = 16;
  localparam int unsigned ARRAY_H    = 4;
  localparam int unsigned ARRAY_W    = 4;
  localparam int unsigned PAD_D      = 2;
  localparam int unsigned TOT_DEPTH  = ARRAY_H * PAD_D;
  localparam int unsigned DATA_W     = TOT_DEPTH * ELEM_W;
  // Both banks of the shift buffer together
  localparam int unsigned BUF_SLOTS  = 2 * ARRAY_H;
  localparam int unsigned ROW_IDX_W  = $clog2(ARRAY_W);
  localparam int unsigned SLOT_IDX_W = $clog2(ARRAY_H);

  typedef logic [ELEM_W-1:0]            elem_t;
  typedef logic [DATA_W-1:0]            data_word_t;
  typedef elem_t [ARRAY_W-1:0]          pad_col_t;
  typedef logic [$clog2(TOT_DEPTH)-1:0] pad_addr_t;
  // MSB selects the bank, the low bits select the slot
  typedef logic [SLOT_IDX_W:0]          slot_addr_t;
  typedef logic [ROW_IDX_W:0]           row_cnt_t;
  typedef logic [$clog2(TOT_DEPTH):0]   col_cnt_t;
  typedef logic [$clog2(BUF_SLOTS):0]   fill_cnt_t;

  typedef struct packed {
    logic     pad_setup;
    logic     load;
    logic     h_shift;
    logic     rst_w_index;
    logic     last_x;
    row_cnt_t width;
    col_cnt_t height;
    col_cnt_t slots;
  } xbuf_ctrl_t;

  typedef struct packed {
    logic full;
    logic empty;
  } xbuf_flags_t;

  typedef enum logic [2:0] {
    PRELOAD,
    FAST_FILL,
    WAIT_FIRST_READ,
    WAIT_SHIFT,
    FILL,
    PAD_EMPTY
  } xbuf_state_e;

endpackage

`default_nettype wire

// ==== verilog/xbuf_shift_scm.sv ====
/*
  Double-banked column buffer, ARRAY_H slots per bank.
  One bank is filled while the other is presented to the array.
  The whole selected bank is registered on read_en_i and held otherwise.
*/
`timescale 1ns/1ps
`default_nettype none

module xbuf_shift_scm
  import xbuf_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       clear_i,
  input  wire logic       write_en_i,
  input  wire slot_addr_t write_addr_i,
  input  wire pad_col_t   wdata_i,
  input  wire logic       read_en_i,
  input  wire logic       read_bank_i,
  output pad_col_t [ARRAY_H-1:0] rdata_o
);

  pad_col_t [ARRAY_H-1:0] bank_q [2];
  logic                   wr_bank;
  logic [SLOT_IDX_W-1:0]  wr_slot;

  assign wr_bank = write_addr_i[SLOT_IDX_W];
  assign wr_slot = write_addr_i[SLOT_IDX_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_q[0] <= '0;
      bank_q[1] <= '0;
    end else if (clear_i) begin
      bank_q[0] <= '0;
      bank_q[1] <= '0;
    end else if (write_en_i) begin
      bank_q[wr_bank][wr_slot] <= wdata_i;
    end
  end

  // Output only moves on a shift, so a missing shift stalls the array
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (clear_i) begin
      rdata_o <= '0;
    end else if (read_en_i) begin
      rdata_o <= bank_q[read_bank_i];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/xbuf_top.sv ====
/*
  X operand staging path: pad memory, fill controller and shift buffer.
  x_buffer_o is indexed [row][pe] and changes only on the edge after h_shift.
*/
`timescale 1ns/1ps
`default_nettype none

module xbuf_top
  import xbuf_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       clear_i,
  input  wire xbuf_ctrl_t ctrl_i,
  input  wire data_word_t data_i,
  output xbuf_flags_t     flags_o,
  output elem_t [ARRAY_W-1:0][ARRAY_H-1:0] x_buffer_o
);

  logic                   pad_we, pad_re, buf_we, buf_wzero, buf_rbank;
  row_cnt_t               pad_wrow;
  pad_addr_t              pad_raddr;
  slot_addr_t             buf_waddr;
  pad_col_t               pad_rdata, buf_wdata;
  pad_col_t [ARRAY_H-1:0] buf_rdata;

  xbuf_ctrl xbuf_ctrl_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .ctrl_i      (ctrl_i),
    .flags_o     (flags_o),
    .pad_we_o    (pad_we),
    .pad_wrow_o  (pad_wrow),
    .pad_re_o    (pad_re),
    .pad_raddr_o (pad_raddr),
    .buf_we_o    (buf_we),
    .buf_waddr_o (buf_waddr),
    .buf_wzero_o (buf_wzero),
    .buf_rbank_o (buf_rbank)
  );

  xbuf_pad_scm xbuf_pad_scm_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .write_en_i  (pad_we),
    .write_row_i (pad_wrow),
    .wdata_i     (data_i),
    .read_en_i   (pad_re),
    .read_addr_i (pad_raddr),
    .rdata_o     (pad_rdata)
  );

  // Columns past the programmed height enter the buffer as zeros
  assign buf_wdata = buf_wzero ? '0 : pad_rdata;

  xbuf_shift_scm xbuf_shift_scm_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .write_en_i   (buf_we),
    .write_addr_i (buf_waddr),
    .wdata_i      (buf_wdata),
    .read_en_i    (ctrl_i.h_shift),
    .read_bank_i  (buf_rbank),
    .rdata_o      (buf_rdata)
  );

  // Buffer is slot-major, the array wants row-major
  for (genvar w = 0; w < ARRAY_W; w++) begin : g_row
    for (genvar h = 0; h < ARRAY_H; h++) begin : g_pe
      assign x_buffer_o[w][h] = buf_rdata[h][w];
    end
  end

endmodule

`default_nettype wire
